// File: verilog.f
common/ls1u_pkg.sv
src/alu_slice_181.sv
core/ls1u_core.sv
src/data_ram.sv
src/ls1u_subsys.sv
verification/tb_clkgen.sv
verification/ls1u_chk.sv
verification/tb_ls1u.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_ls1u -o sim_ls1u
out=$(./obj_dir/sim_ls1u 2>&1) || true
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// File: verification/tb_ls1u.sv
`timescale 1ns/100ps

module tb_ls1u;
    import ls1u_pkg::*;

    localparam logic [ADDR_W-1:0] IVEC = 24'h000300;

    logic                clk;
    logic                WAIT;
    logic                int_req;
    logic [ADDR_W-1:0]   ivec_addr;
    logic                in_isr;
    logic [ADDR_W-1:0]   iaddr;
    logic [ADDR_W-1:0]   iaddr_next;
    logic [INSTR_W-1:0]  instr;
    dmem_req_t           mem_wr;

    logic [INSTR_W-1:0]  imem [1024];
    logic [31:0]         exp_q [$];             // {addr, data}
    string               name_q [$];
    logic [31:0]         lfsr_state;
    logic [31:0]         got, want;
    string               test_name;
    int                  pc_asm, n_instr, int_at, limit, cycles;
    logic                wr_prev, isr_done;

    tb_clkgen u_clk (.clk(clk));

    ls1u_subsys DUT (
        .clk        (clk),
        .WAIT       (WAIT),
        .int_req    (int_req),
        .ivec_addr  (ivec_addr),
        .in_isr     (in_isr),
        .iaddr      (iaddr),
        .iaddr_next (iaddr_next),
        .instr      (instr),
        .mem_wr     (mem_wr)
    );

    bind ls1u_core ls1u_chk u_chk (
        .clk   (clk),
        .WAIT  (WAIT),
        .dreq  (dreq),
        .drsp  (drsp),
        .iaddr (iaddr)
    );

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // 74181 pair with active-high data, result {cout, f}
    function automatic logic [8:0] alu_ref(input logic [3:0] s, input logic m, input logic cin,
                                           input logic [7:0] a, input logic [7:0] b);
        logic [7:0] lg;
        logic [8:0] ar, ea, eb, enb, ec;
        ea  = {1'b0, a};
        eb  = {1'b0, b};
        enb = {1'b0, ~b};
        ec  = {8'h00, cin};
        case (s)
            4'h0:    lg = ~a;
            4'h1:    lg = ~(a | b);
            4'h2:    lg = ~a & b;
            4'h3:    lg = 8'h00;
            4'h4:    lg = ~(a & b);
            4'h5:    lg = ~b;
            4'h6:    lg = a ^ b;
            4'h7:    lg = a & ~b;
            4'h8:    lg = ~a | b;
            4'h9:    lg = ~(a ^ b);
            4'ha:    lg = b;
            4'hb:    lg = a & b;
            4'hc:    lg = 8'hff;
            4'hd:    lg = a | ~b;
            4'he:    lg = a | b;
            default: lg = a;
        endcase
        case (s)
            4'h0:    ar = ea + ec;
            4'h1:    ar = (ea | eb) + ec;
            4'h2:    ar = (ea | enb) + ec;
            4'h3:    ar = 9'h0ff + ec;
            4'h4:    ar = ea + (ea & enb) + ec;
            4'h5:    ar = (ea | eb) + (ea & enb) + ec;
            4'h6:    ar = ea + enb + ec;        // A minus B minus 1
            4'h7:    ar = (ea & enb) + 9'h0ff + ec;
            4'h8:    ar = ea + (ea & eb) + ec;
            4'h9:    ar = ea + eb + ec;
            4'ha:    ar = (ea | enb) + (ea & eb) + ec;
            4'hb:    ar = (ea & eb) + 9'h0ff + ec;
            4'hc:    ar = ea + ea + ec;
            4'hd:    ar = (ea | eb) + ea + ec;
            4'he:    ar = (ea | enb) + ea + ec;
            default: ar = ea + 9'h0ff + ec;
        endcase
        return m ? {ar[8], lg} : ar;            // Carry follows arithmetic in both modes
    endfunction

    function automatic logic [7:0] shift_ref(input funct_e fn, input logic [7:0] a,
                                             input logic [7:0] b);
        case (fn)
            FN_SHL_A:  return a << 1;
            FN_ROL_AB: return {a[6:0], b[7]};
            FN_SHR_A:  return a >> 1;
            FN_SAR_A:  return $signed(a) >>> 1;
            FN_SHL_B:  return b << 1;
            FN_SHR_B:  return b >> 1;
            FN_SAR_B:  return $signed(b) >>> 1;
            default:   return {a[0], b[7:1]};   // ROR through A's low bit
        endcase
    endfunction

    task automatic emit(input funct_e fn, input logic [2:0] d, input logic [7:0] imm);
        imem[pc_asm] = {fn, d, imm};
        pc_asm++;
        n_instr++;
    endtask

    task automatic set_addr(input logic [23:0] addr);
        emit(FN_LDI, A0, addr[7:0]);
        emit(FN_LDI, A1, addr[15:8]);
        emit(FN_LDI, A2, addr[23:16]);
    endtask

    task automatic expect_store(input logic [23:0] addr, input logic [7:0] data, input string nm);
        exp_q.push_back({addr, data});
        name_q.push_back(nm);
    endtask

    task automatic build_program();
        logic [7:0] a, b, mk;
        logic [3:0] s;
        logic       m, cin, taken;
        logic [2:0] cond;
        logic [7:0] jimm;
        logic [8:0] res;
        funct_e     shifts [8];
        int         t;
        shifts = '{FN_SHL_A, FN_ROL_AB, FN_SHR_A, FN_SAR_A,
                   FN_SHL_B, FN_SHR_B, FN_SAR_B, FN_ROR_AB};
        set_addr(24'h123456);                   // Plain immediate store
        emit(FN_LDI, MDR, 8'ha5);
        expect_store(24'h123456, 8'ha5, "imm_store");
        for (int i = 0; i < 20; i++)
        begin
            a = rand_bits(8);
            b = rand_bits(8);
            s = 4'(rand_bits(4));
            m = 1'(rand_bits(1));
            cin = 1'(rand_bits(1));
            emit(FN_LDI, A, a);
            emit(FN_LDI, B, b);
            set_addr(24'h000100 + 24'(i));
            emit(FN_ALU, MDR, {s, m, cin, 2'b00});
            res = alu_ref(s, m, cin, a, b);
            expect_store(24'h000100 + 24'(i), res[7:0], $sformatf("alu_%0d", i));
        end
        for (int i = 0; i < 8; i++)
        begin
            a = rand_bits(8);
            b = rand_bits(8);
            emit(FN_LDI, A, a);
            emit(FN_LDI, B, b);
            set_addr(24'h000140 + 24'(i));
            emit(shifts[i], MDR, 8'h00);
            expect_store(24'h000140 + 24'(i), shift_ref(shifts[i], a, b), shifts[i].name());
        end
        for (int k = 0; k < 8; k++)
        begin
            case (k / 2)                        // Even k taken, odd k not taken
                0:
                begin
                    cond = JC_APOS;
                    a    = (k % 2) ? 8'hc2 : 8'h35;
                    b    = 8'h00;
                    jimm = 8'h00;
                end
                1:
                begin
                    cond = JC_BPOS;
                    a    = 8'h00;
                    b    = (k % 2) ? 8'h91 : 8'h6e;
                    jimm = 8'h00;
                end
                2:
                begin
                    cond = JC_NEQ;
                    a    = 8'h5c;
                    b    = (k % 2) ? 8'h5c : 8'h17;
                    jimm = 8'h98;
                end
                default:
                begin
                    cond = JC_NC;
                    a    = 8'h80;
                    b    = (k % 2) ? 8'h90 : 8'h21;
                    jimm = 8'h90;
                end
            endcase
            case (cond)
                JC_APOS: taken = ~a[7];
                JC_BPOS: taken = ~b[7];
                JC_NEQ:
                begin
                    res   = alu_ref(4'h9, 1'b1, 1'b0, a, b);
                    taken = res[7:0] != 8'hff;
                end
                default:
                begin
                    res   = alu_ref(4'h9, 1'b0, 1'b0, a, b);
                    taken = ~res[8];
                end
            endcase
            emit(FN_LDI, A, a);
            emit(FN_LDI, B, b);
            t = pc_asm + 3 + 1 + 4;
            set_addr(24'(t));
            emit(FN_JMP, cond, jimm);
            set_addr(24'h000180 + 24'(k));
            mk = 8'h40 + 8'(k);
            emit(FN_LDI, MDR, mk);
            set_addr(24'h000180 + 24'(k));
            emit(FN_LDI, MDR, 8'h80 + 8'(k));
            if (!taken)
                expect_store(24'h000180 + 24'(k), mk, $sformatf("jump_fall_%0d", k));
            expect_store(24'h000180 + 24'(k), 8'h80 + 8'(k), $sformatf("jump_target_%0d", k));
        end
        set_addr(24'h0a0b0c);
        emit(FN_NOP, 3'd0, 8'h00);
        emit(FN_NOP, 3'd0, 8'h00);
        int_at = pc_asm;
        emit(FN_NOP, 3'd0, 8'h00);              // Interrupted here
        emit(FN_LDI, MDR, 8'h77);
        expect_store(24'h0a0b0c, 8'h0c, "isr_a0");
        expect_store(24'h0003f0, 8'hee, "isr_marker");
        expect_store(24'h0a0b0c, 8'h77, "isr_resume");
        set_addr(24'h000050);
        emit(FN_LDI, MDR, 8'h3d);
        emit(FN_LOAD, C, 8'h00);
        set_addr(24'h000051);
        emit(FN_MOVC, MDR, 8'h00);
        expect_store(24'h000050, 8'h3d, "load_src");
        expect_store(24'h000051, 8'h3d, "load_copy");
        t = pc_asm;
        pc_asm = int'(IVEC);                    // Interrupt handler
        emit(FN_MOVX, MDR, 8'h03);
        set_addr(24'h0003f0);
        emit(FN_LDI, MDR, 8'hee);
        emit(FN_JMP, JC_RET, 8'h00);
        pc_asm = t;
    endtask

    always @(negedge clk)
        instr <= imem[iaddr[9:0]];

    always @(posedge clk)
    begin
        if (!WAIT && mem_wr.write && !wr_prev)
        begin
            assert (exp_q.size() != 0)
            else report_fail("a store appeared that no test expected");
            want = exp_q.pop_front();
            test_name = name_q.pop_front();
            got = {mem_wr.addr, mem_wr.wdata};
            assert (got == want)
            else report_fail($sformatf("[FAIL] %s expected %h actual %h", test_name, want, got));
        end
        wr_prev <= mem_wr.write;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
            report_fail("timeout, the expected stores did not all appear");
    end

    // Interrupt entry and return
    initial
    begin
        @(negedge clk);
        while (WAIT || iaddr != 24'(int_at))
            @(negedge clk);
        int_req = 1'b1;
        @(posedge clk);
        assert (iaddr_next == IVEC)
        else report_fail($sformatf("[FAIL] isr_next expected %h actual %h", IVEC, iaddr_next));
        @(negedge clk);
        assert (in_isr)
        else report_fail("in_isr did not rise when the interrupt was taken");
        assert (iaddr == IVEC)
        else report_fail($sformatf("[FAIL] isr_entry expected %h actual %h", IVEC, iaddr));
        int_req = 1'b0;
        while (in_isr)
            @(negedge clk);
        assert (iaddr == 24'(int_at + 1))
        else report_fail($sformatf("[FAIL] isr_return expected %h actual %h",
                                   24'(int_at + 1), iaddr));
        isr_done = 1'b1;
    end

    initial
    begin
        WAIT = 1'b1;
        int_req = 1'b0;
        ivec_addr = IVEC;
        instr = '0;
        wr_prev = 1'b0;
        isr_done = 1'b0;
        cycles = 0;
        limit = 1000000;
        lfsr_state = 32'hf4ab_ee67;
        pc_asm = 0;
        n_instr = 0;
        for (int i = 0; i < 1024; i++)
            imem[i] = {5'd0, 1'b0, i[9:0]};     // NOPs tagged with their address
        build_program();
        limit = n_instr * (RAM_LAT + 4) + 200;
        repeat (5) @(negedge clk);
        WAIT = 1'b0;
        while (exp_q.size() != 0 || !isr_done)
            @(posedge clk);
        repeat (10) @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verification/ls1u_chk.sv
`timescale 1ns/100ps

module ls1u_chk (
    input logic                        clk,
    input logic                        WAIT,
    input ls1u_pkg::dmem_req_t         dreq,
    input ls1u_pkg::dmem_rsp_t         drsp,
    input logic [ls1u_pkg::ADDR_W-1:0] iaddr
);
    import ls1u_pkg::*;

    logic pending;

    assign pending = dreq.read | dreq.write;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (WAIT)
        !(dreq.read && dreq.write))
        else $error("read and write requested together");

    // Request is held until the RAM answers
    req_held: assert property (@(posedge clk) disable iff (WAIT)
        (pending && !drsp.finish) |=> pending)
        else $error("data request dropped before finish");

    pc_frozen: assert property (@(posedge clk) disable iff (WAIT)
        (pending && !drsp.finish) |=> $stable(iaddr))
        else $error("iaddr moved while a data request was pending");

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk
);
    localparam real HALF_PERIOD = 20.0;         // 40 ns period

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: src/ls1u_subsys.sv
`timescale 1ns/100ps

module ls1u_subsys (
    input  logic                         clk,
    input  logic                         WAIT,
    input  logic                         int_req,
    input  logic [ls1u_pkg::ADDR_W-1:0]  ivec_addr,
    output logic                         in_isr,
    output logic [ls1u_pkg::ADDR_W-1:0]  iaddr,
    output logic [ls1u_pkg::ADDR_W-1:0]  iaddr_next,
    input  logic [ls1u_pkg::INSTR_W-1:0] instr,
    output ls1u_pkg::dmem_req_t          mem_wr
);
    import ls1u_pkg::*;

    dmem_req_t dreq;
    dmem_rsp_t drsp;

    ls1u_core u_core (
        .clk        (clk),
        .WAIT       (WAIT),
        .int_req    (int_req),
        .ivec_addr  (ivec_addr),
        .in_isr     (in_isr),
        .iaddr      (iaddr),
        .iaddr_next (iaddr_next),
        .instr      (instr),
        .dreq       (dreq),
        .drsp       (drsp)
    );

    data_ram u_ram (
        .clk  (clk),
        .WAIT (WAIT),
        .req  (dreq),
        .rsp  (drsp)
    );

    // Store monitor sees the same request the RAM does
    assign mem_wr = dreq;

endmodule

// File: src/data_ram.sv
`timescale 1ns/100ps

module data_ram (
    input  logic                clk,
    input  logic                WAIT,
    input  ls1u_pkg::dmem_req_t req,
    output ls1u_pkg::dmem_rsp_t rsp
);
    import ls1u_pkg::*;

    logic [DATA_W-1:0] mem [RAM_DEPTH];
    logic [RAM_AW-1:0] ram_addr;
    logic [LAT_W-1:0]  cnt;
    logic [DATA_W-1:0] rdata;
    logic              busy, armed, fin;
    logic              req_any, start, done;

    assign req_any  = req.read | req.write;
    assign start    = req_any & armed;
    assign done     = busy && (cnt == LAT_W'(RAM_LAT - 1));
    assign ram_addr = req.addr[RAM_AW-1:0];

    always_ff @(posedge clk or posedge WAIT)
    begin
        if (WAIT)
        begin
            busy  <= 1'b0;
            armed <= 1'b1;
            cnt   <= '0;
            fin   <= 1'b0;
        end
        else
        begin
            fin <= done;
            if (start)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
            else if (done)
                busy <= 1'b0;
            else if (busy)
                cnt <= cnt + LAT_W'(1);

            // A held request must drop or finish before it counts again
            if (start)
                armed <= 1'b0;
            else if (!req_any || fin)
                armed <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (done)
        begin
            if (req.write)
                mem[ram_addr] <= req.wdata;
            rdata <= mem[ram_addr];
        end
    end

    assign rsp = '{finish: fin, rdata: rdata};

endmodule

// File: core/ls1u_core.sv
`timescale 1ns/100ps

module ls1u_core (
    input  logic                         clk,
    input  logic                         WAIT,
    input  logic                         int_req,
    input  logic [ls1u_pkg::ADDR_W-1:0]  ivec_addr,
    output logic                         in_isr,
    output logic [ls1u_pkg::ADDR_W-1:0]  iaddr,
    output logic [ls1u_pkg::ADDR_W-1:0]  iaddr_next,
    input  logic [ls1u_pkg::INSTR_W-1:0] instr,
    output ls1u_pkg::dmem_req_t          dreq,
    input  ls1u_pkg::dmem_rsp_t          drsp
);
    import ls1u_pkg::*;

    funct_e            funct;
    jcond_e            jcond;
    dst_e              dst;
    wbsrc_e            wb_src;
    logic [DATA_W-1:0] imm;
    logic [2:0]        xreg_sel;
    logic              reg_en, jmp_en, xreg_en;

    logic [ADDR_W-1:0] pc, pc_next, pc_inc, jaddr;
    logic [DATA_W-1:0] a, b, c, d, a0, a1, a2, mdr;
    logic [DATA_W-1:0] ret0, ret1, ret2;        // Return address
    logic [DATA_W-1:0] rta0, rta1, rta2;        // A0-A2 saved on interrupt entry
    logic [DATA_W-1:0] xreg, wb;
    logic [DATA_W-1:0] a0_new, a1_new, a2_new;
    logic              req_rd, req_wr, stall;
    logic              load_done, advance, take_int, reg_we;
    logic              jmp, ret_sel;
    logic [DATA_W-1:0] alu_f;
    logic              alu_c1, alu_co, eq_lo, eq_hi, alu_eq;

    assign funct    = funct_e'(instr[15:11]);
    assign jcond    = jcond_e'(instr[10:8]);
    assign dst      = dst_e'(instr[10:8]);
    assign imm      = instr[7:0];
    assign xreg_sel = instr[2:0];

    always_comb
    begin
        case (funct)
            FN_ALU, FN_TOX: wb_src = SRC_ALU;
            FN_MOVX:        wb_src = SRC_XREG;
            FN_LOAD:        wb_src = SRC_RAM;
            FN_MOVC:        wb_src = SRC_C;
            FN_LDI:         wb_src = SRC_IMM;
            FN_MOVD:        wb_src = SRC_D;
            FN_SHL_A:       wb_src = SRC_SHL_A;
            FN_ROL_AB:      wb_src = SRC_ROL_AB;
            FN_SHR_A:       wb_src = SRC_SHR_A;
            FN_SAR_A:       wb_src = SRC_SAR_A;
            FN_SHL_B:       wb_src = SRC_SHL_B;
            FN_SHR_B:       wb_src = SRC_SHR_B;
            FN_SAR_B:       wb_src = SRC_SAR_B;
            FN_ROR_AB:      wb_src = SRC_ROR_AB;
            default:        wb_src = SRC_NONE;  // NOP, JMP and unused codes
        endcase
    end

    assign xreg_en = (funct == FN_TOX);
    assign jmp_en  = (funct == FN_JMP);
    assign reg_en  = (wb_src != SRC_NONE) && !xreg_en;

    // A load waits in place for its finish, a store stalls the next instruction
    assign stall     = req_rd | req_wr;
    assign load_done = req_rd & drsp.finish;
    assign advance   = (!stall && funct != FN_LOAD) || load_done;
    assign reg_we    = advance & reg_en;
    assign take_int  = advance & int_req & ~in_isr;

    alu_slice_181 u_alu_lo (
        .a    (a[3:0]),
        .b    (b[3:0]),
        .s    (instr[7:4]),
        .m    (instr[3]),
        .cin  (instr[2]),
        .f    (alu_f[3:0]),
        .cout (alu_c1),
        .eqv  (eq_lo),
        .g    (),
        .p    ()
    );

    alu_slice_181 u_alu_hi (
        .a    (a[7:4]),
        .b    (b[7:4]),
        .s    (instr[7:4]),
        .m    (instr[3]),
        .cin  (alu_c1),                         // Ripple from low slice
        .f    (alu_f[7:4]),
        .cout (alu_co),
        .eqv  (eq_hi),
        .g    (),
        .p    ()
    );

    assign alu_eq = eq_lo & eq_hi;

    always_comb
    begin
        jmp     = 1'b0;
        ret_sel = 1'b0;
        if (jmp_en)
        begin
            case (jcond)
                JC_RET:
                begin
                    jmp     = 1'b1;
                    ret_sel = 1'b1;
                end
                JC_APOS:   jmp = ~a[7];
                JC_BPOS:   jmp = ~b[7];
                JC_NEQ:    jmp = ~alu_eq;
                JC_NC:     jmp = ~alu_co;
                JC_ALWAYS: jmp = 1'b1;
                default:   jmp = 1'b0;
            endcase
        end
    end

    assign jaddr = ret_sel ? {ret2, ret1, ret0} : {a2, a1, a0};

    always_comb
    begin
        case (xreg_sel)
            3'd0:    xreg = ret0;
            3'd1:    xreg = ret1;
            3'd2:    xreg = ret2;
            3'd3:    xreg = rta0;
            3'd4:    xreg = rta1;
            3'd5:    xreg = rta2;
            default: xreg = '0;
        endcase
    end

    // Write-back bus
    always_comb
    begin
        case (wb_src)
            SRC_C:      wb = c;
            SRC_ALU:    wb = alu_f;
            SRC_RAM:    wb = drsp.rdata;
            SRC_IMM:    wb = imm;
            SRC_D:      wb = d;
            SRC_XREG:   wb = xreg;
            SRC_SHL_A:  wb = {a[6:0], 1'b0};
            SRC_ROL_AB: wb = {a[6:0], b[7]};
            SRC_SHR_A:  wb = {1'b0, a[7:1]};
            SRC_SAR_A:  wb = {a[7], a[7:1]};
            SRC_SHL_B:  wb = {b[6:0], 1'b0};
            SRC_SHR_B:  wb = {1'b0, b[7:1]};
            SRC_SAR_B:  wb = {b[7], b[7:1]};
            SRC_ROR_AB: wb = {a[0], b[7:1]};
            default:    wb = '0;
        endcase
    end

    assign pc_inc = pc + ADDR_W'(1);

    always_comb
    begin
        if (!advance)
            pc_next = pc;
        else if (take_int)
            pc_next = ivec_addr;
        else if (jmp)
            pc_next = jaddr;
        else
            pc_next = pc_inc;
    end

    always_ff @(posedge clk or posedge WAIT)
    begin
        if (WAIT)
            pc <= '0;
        else
            pc <= pc_next;
    end

    always_ff @(posedge clk)
    begin
        if (advance && ret_sel)
        begin
            a0 <= rta0;                         // Pop on return
            a1 <= rta1;
            a2 <= rta2;
        end
        else if (reg_we)
        begin
            case (dst)
                C:   c   <= wb;
                A:   a   <= wb;
                B:   b   <= wb;
                A0:  a0  <= wb;
                A1:  a1  <= wb;
                A2:  a2  <= wb;
                D:   d   <= wb;
                MDR: mdr <= wb;
            endcase
        end
    end

    // Values the address registers hold once this instruction retires
    assign a0_new = (reg_we && dst == A0) ? wb : a0;
    assign a1_new = (reg_we && dst == A1) ? wb : a1;
    assign a2_new = (reg_we && dst == A2) ? wb : a2;

    always_ff @(posedge clk)
    begin
        if (take_int)
        begin
            {ret2, ret1, ret0} <= jmp ? jaddr : pc_inc;
            rta0 <= a0_new;
            rta1 <= a1_new;
            rta2 <= a2_new;
        end
        else if (advance && xreg_en)
        begin
            case (xreg_sel)
                3'd0:    ret0 <= wb;
                3'd1:    ret1 <= wb;
                3'd2:    ret2 <= wb;
                3'd3:    rta0 <= wb;
                3'd4:    rta1 <= wb;
                3'd5:    rta2 <= wb;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge WAIT)
    begin
        if (WAIT)
            in_isr <= 1'b0;
        else if (take_int)
            in_isr <= 1'b1;
        else if (advance && ret_sel)
            in_isr <= 1'b0;
    end

    always_ff @(posedge clk or posedge WAIT)
    begin
        if (WAIT)
        begin
            req_rd <= 1'b0;
            req_wr <= 1'b0;
        end
        else
        begin
            if (drsp.finish)
            begin
                req_rd <= 1'b0;
                req_wr <= 1'b0;
            end
            if (!stall && funct == FN_LOAD)
                req_rd <= 1'b1;
            if (reg_we && dst == MDR)
                req_wr <= 1'b1;                 // Store follows the MDR write
        end
    end

    assign dreq       = '{read: req_rd, write: req_wr, addr: {a2, a1, a0}, wdata: mdr};
    assign iaddr      = pc;
    assign iaddr_next = pc_next;

endmodule

// File: src/alu_slice_181.sv
`timescale 1ns/100ps

module alu_slice_181 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic [3:0] s,
    input  logic       m,
    input  logic       cin,
    output logic [3:0] f,
    output logic       cout,
    output logic       eqv,
    output logic       g,
    output logic       p
);
    logic [3:0] x, y;                           // Adder operands picked by s
    logic [3:0] lf;                             // Logic mode result
    logic [4:0] sum;
    logic [3:0] gi, pi;

    // Arithmetic mode is always x + y + cin
    always_comb
    begin
        case (s)
            4'h0:    {x, y} = {a, 4'h0};
            4'h1:    {x, y} = {a | b, 4'h0};
            4'h2:    {x, y} = {a | ~b, 4'h0};
            4'h3:    {x, y} = {4'h0, 4'hf};     // Minus one
            4'h4:    {x, y} = {a, a & ~b};
            4'h5:    {x, y} = {a | b, a & ~b};
            4'h6:    {x, y} = {a, ~b};          // A - B - 1
            4'h7:    {x, y} = {a & ~b, 4'hf};
            4'h8:    {x, y} = {a, a & b};
            4'h9:    {x, y} = {a, b};
            4'ha:    {x, y} = {a | ~b, a & b};
            4'hb:    {x, y} = {a & b, 4'hf};
            4'hc:    {x, y} = {a, a};           // Doubling
            4'hd:    {x, y} = {a | b, a};
            4'he:    {x, y} = {a | ~b, a};
            default: {x, y} = {a, 4'hf};
        endcase
    end

    always_comb
    begin
        case (s)
            4'h0:    lf = ~a;
            4'h1:    lf = ~(a | b);
            4'h2:    lf = ~a & b;
            4'h3:    lf = 4'h0;
            4'h4:    lf = ~(a & b);
            4'h5:    lf = ~b;
            4'h6:    lf = a ^ b;
            4'h7:    lf = a & ~b;
            4'h8:    lf = ~a | b;
            4'h9:    lf = ~(a ^ b);
            4'ha:    lf = b;
            4'hb:    lf = a & b;
            4'hc:    lf = 4'hf;
            4'hd:    lf = a | ~b;
            4'he:    lf = a | b;
            default: lf = a;
        endcase
    end

    assign sum  = {1'b0, x} + {1'b0, y} + {4'b0, cin};
    assign f    = m ? lf : sum[3:0];
    assign cout = sum[4];                       // Carry logic ignores m, as on the chip
    assign eqv  = &f;

    // Group lookahead terms
    assign gi = x & y;
    assign pi = x | y;
    assign g  = gi[3] | (pi[3] & gi[2]) | (&pi[3:2] & gi[1]) | (&pi[3:1] & gi[0]);
    assign p  = &pi;

endmodule

// File: common/ls1u_pkg.sv
package ls1u_pkg;

    localparam int ADDR_W    = 24;              // Instruction and data address width
    localparam int DATA_W    = 8;
    localparam int INSTR_W   = 16;
    localparam int RAM_AW    = 8;               // Only the low address bits reach the RAM
    localparam int RAM_DEPTH = 1 << RAM_AW;
    localparam int RAM_LAT   = 2;               // Cycles from accepted request to finish
    localparam int LAT_W     = $clog2(RAM_LAT + 1);

    // Function field, instr[15:11]
    typedef enum logic [4:0] {
        FN_NOP    = 5'd0,
        FN_JMP    = 5'd1,
        FN_ALU    = 5'd2,
        FN_MOVX   = 5'd3,                       // Extra register to dst
        FN_LOAD   = 5'd4,
        FN_MOVC   = 5'd5,
        FN_LDI    = 5'd6,
        FN_MOVD   = 5'd7,
        FN_TOX    = 5'd8,                       // ALU result to extra register
        FN_SHL_A  = 5'd13,
        FN_ROL_AB = 5'd16,
        FN_SHR_A  = 5'd18,
        FN_SAR_A  = 5'd20,
        FN_SHL_B  = 5'd22,
        FN_SHR_B  = 5'd24,
        FN_SAR_B  = 5'd26,
        FN_ROR_AB = 5'd28
    } funct_e;

    typedef enum logic [2:0] {
        JC_RET    = 3'd0,
        JC_APOS   = 3'd1,
        JC_BPOS   = 3'd2,
        JC_NEQ    = 3'd3,
        JC_NC     = 3'd4,
        JC_ALWAYS = 3'd5
    } jcond_e;

    typedef enum logic [2:0] {
        C   = 3'd0,
        A   = 3'd1,
        B   = 3'd2,
        A0  = 3'd3,
        A1  = 3'd4,
        A2  = 3'd5,
        D   = 3'd6,
        MDR = 3'd7                              // Writing it queues a store
    } dst_e;

    // Write-back bus sources
    typedef enum logic [3:0] {
        SRC_C, SRC_ALU, SRC_RAM, SRC_IMM, SRC_D, SRC_XREG,
        SRC_SHL_A, SRC_ROL_AB, SRC_SHR_A, SRC_SAR_A,
        SRC_SHL_B, SRC_SHR_B, SRC_SAR_B, SRC_ROR_AB,
        SRC_NONE
    } wbsrc_e;

    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic              finish;              // One cycle, rdata valid with it
        logic [DATA_W-1:0] rdata;
    } dmem_rsp_t;

endpackage
